// File: Makefile
VERILATOR ?= verilator
TOP       ?= cart_slot_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: src.f
verilog/msx_cart_pkg.sv
verilog/cart_ascii8.sv
verilog/cart_ascii16.sv
verilog/mapper_konami.sv
verilog/mappers.sv
verilog/cart_slot.sv
verif/cart_slot_assertions.sv
verif/cart_slot_tb.sv

// File: verif/cart_slot_assertions.sv
module cart_slot_assertions import msx_cart_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input cpu_bus_t    cpu,
    input memory_bus_t memory
);

    // Never ROM and SRAM together
    cs_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(memory.rom_cs && memory.sram_cs))
        else $error("rom_cs and sram_cs active in the same cycle");

    // ROM is read only
    rom_read_only: assert property (@(posedge clk) disable iff (!rst_n)
        memory.rom_cs |-> memory.rnw)
        else $error("rom_cs with a write");

    // One cycle behind the CPU strobe
    req_follows_cpu: assert property (@(posedge clk) disable iff (!rst_n)
        memory.req |-> $past(cpu.req))
        else $error("memory.req without cpu.req one cycle before");

    // Held quiet in reset
    idle_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!memory.req && !memory.rom_cs && !memory.sram_cs))
        else $error("memory outputs active during reset");

endmodule

bind mappers cart_slot_assertions cart_slot_assertions_inst (
    .clk    (clk),
    .rst_n  (rst_n),
    .cpu    (cpu),
    .memory (memory)
);

// File: verif/cart_slot_tb.sv
module cart_slot_tb import msx_cart_pkg::*; ();

    localparam int REQ_TIMEOUT = 3;     // Idle cycles to watch for a memory request

    typedef struct packed {
        mapper_cfg_t cfg;
        cpu_bus_t    cpu;
        memory_bus_t exp;               // exp.req clear means no request expected
        logic        chain;             // Next entry follows on the very next cycle
    } entry_t;

    logic        clk;
    logic        rst_n;
    cpu_bus_t    cpu;
    mapper_cfg_t cfg;
    memory_bus_t memory;

    int          seed;
    entry_t      tbl[$];
    string       names[$];
    logic [7:0]  a8_bank [4];           // Reference copies of the bank registers
    logic [7:0]  a16_bank [2];
    logic [7:0]  kon_bank [4];          // Entry 0 is the fixed first page
    logic        test_ok;
    int          pass_cnt;
    int          fail_cnt;
    int          lat;
    int          i;

    cart_slot cart_slot_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu    (cpu),
        .cfg    (cfg),
        .memory (memory)
    );

    always #2 clk = ~clk;

    function automatic logic [7:0] rand8();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic logic [15:0] rand_off(input logic [15:0] mask);
        logic [31:0] r;
        r = $random(seed);
        return r[15:0] & mask;
    endfunction

    function automatic logic [15:0] page_base(input int p);
        return 16'h4000 + 16'(p) * 16'h2000;    // 8 KB pages from 0x4000
    endfunction

    function automatic mapper_cfg_t make_cfg(input mapper_typ_e t, input logic [7:0] mask,
                                             input logic sram);
        mapper_cfg_t g;
        g.typ      = t;
        g.rom_mask = mask;
        g.sram_en  = sram;
        return g;
    endfunction

    function automatic cpu_bus_t read_strobe(input logic [15:0] a);
        cpu_bus_t c;
        c.req   = 1'b1;
        c.rnw   = 1'b1;
        c.addr  = a;
        c.wdata = rand8();              // Don't care on reads, still copied through
        return c;
    endfunction

    function automatic cpu_bus_t write_strobe(input logic [15:0] a, input logic [7:0] d);
        cpu_bus_t c;
        c.req   = 1'b1;
        c.rnw   = 1'b0;
        c.addr  = a;
        c.wdata = d;
        return c;
    endfunction

    task automatic model_reset();
        for (int k = 0; k < 4; k++) begin
            a8_bank[k]  = 8'h00;
            kon_bank[k] = 8'(k);        // Konami pages come up as banks 0..3
        end
        a16_bank[0] = 8'h00;
        a16_bank[1] = 8'h00;
    endtask

    // Reference model of one strobe, updates its own bank copies
    task automatic model_step(input mapper_cfg_t g, input cpu_bus_t c,
                              output memory_bus_t e);
        logic [15:0] rel;               // Offset into the 0x4000 window
        logic [7:0]  b;
        logic        wr;
        logic        in_win;
        rel     = c.addr - 16'h4000;
        wr      = ~c.rnw;
        in_win  = (c.addr >= 16'h4000) && (c.addr <= 16'hBFFF);
        e       = '0;
        e.rnw   = c.rnw;
        e.wdata = c.wdata;
        if (in_win) begin
            case (g.typ)
                MAP_ASCII8: begin
                    b = a8_bank[rel[14:13]];
                    if (wr && c.addr >= 16'h6000 && c.addr <= 16'h7FFF) begin
                        a8_bank[c.addr[12:11]] = c.wdata;   // 2 KB per register
                    end else if (g.sram_en && b[ASCII8_SRAM_BIT]) begin
                        if (!wr || rel[14]) begin           // Writes in pages 2, 3 only
                            e.req         = 1'b1;
                            e.sram_cs     = 1'b1;
                            e.addr[12:0]  = c.addr[12:0];
                        end
                    end else if (!wr) begin
                        e.req         = 1'b1;
                        e.rom_cs      = 1'b1;
                        e.addr[20:13] = b & g.rom_mask;
                        e.addr[12:0]  = c.addr[12:0];
                    end
                end
                MAP_ASCII16: begin
                    b = a16_bank[rel[14]];
                    if (wr && c.addr >= 16'h6000 && c.addr <= 16'h67FF) begin
                        a16_bank[0] = c.wdata;
                    end else if (wr && c.addr >= 16'h7000 && c.addr <= 16'h77FF) begin
                        a16_bank[1] = c.wdata;
                    end else if (g.sram_en && b[ASCII16_SRAM_BIT]) begin
                        if (!wr || rel[14]) begin           // Page 1 writable
                            e.req        = 1'b1;
                            e.sram_cs    = 1'b1;
                            e.addr[10:0] = c.addr[10:0];
                        end
                    end else if (!wr) begin
                        e.req         = 1'b1;
                        e.rom_cs      = 1'b1;
                        e.addr[21:14] = b & g.rom_mask;
                        e.addr[13:0]  = c.addr[13:0];
                    end
                end
                MAP_KONAMI: begin
                    if (wr) begin
                        if (rel[14:13] != 2'd0) begin
                            kon_bank[rel[14:13]] = c.wdata;
                        end
                    end else begin
                        e.req         = 1'b1;
                        e.rom_cs      = 1'b1;
                        e.addr[20:13] = kon_bank[rel[14:13]] & g.rom_mask;
                        e.addr[12:0]  = c.addr[12:0];
                    end
                end
                default: ;                                  // No mapper, no request
            endcase
        end
    endtask

    task automatic add_entry(input string name, input mapper_cfg_t g, input cpu_bus_t c,
                             input logic chain);
        entry_t en;
        en.cfg   = g;
        en.cpu   = c;
        en.chain = chain;
        model_step(g, c, en.exp);
        tbl.push_back(en);
        names.push_back(name);
    endtask

    task automatic build_table();
        mapper_cfg_t c8;
        mapper_cfg_t c16;
        mapper_cfg_t ck;
        mapper_cfg_t c8s;
        mapper_cfg_t c16s;
        mapper_cfg_t cnone;
        logic [15:0] ra;
        c8    = make_cfg(MAP_ASCII8, 8'h3F, 1'b0);
        c16   = make_cfg(MAP_ASCII16, 8'h7F, 1'b0);
        ck    = make_cfg(MAP_KONAMI, 8'h1F, 1'b0);
        c8s   = make_cfg(MAP_ASCII8, 8'hFF, 1'b1);
        c16s  = make_cfg(MAP_ASCII16, 8'hFF, 1'b1);
        cnone = make_cfg(MAP_NONE, 8'hFF, 1'b0);
        for (int p = 0; p < 4; p++) begin
            add_entry("ascii8 reset bank read", c8,
                      read_strobe(page_base(p) | rand_off(16'h1FFF)), 1'b0);
        end
        add_entry("ascii16 reset bank read", c16, read_strobe(16'h4000 | rand_off(16'h3FFF)), 1'b0);
        add_entry("ascii16 reset bank read", c16, read_strobe(16'h8000 | rand_off(16'h3FFF)), 1'b0);
        for (int p = 0; p < 4; p++) begin
            add_entry("konami reset bank read", ck,
                      read_strobe(page_base(p) | rand_off(16'h1FFF)), 1'b0);
        end
        // Bank switching, each register then its page
        for (int r = 0; r < 4; r++) begin
            ra = 16'h6000 | (16'(r) << 11) | rand_off(16'h07FF);
            add_entry("ascii8 bank write", c8, write_strobe(ra, rand8()), 1'b0);
            add_entry("ascii8 switched read", c8,
                      read_strobe(page_base(r) | rand_off(16'h1FFF)), 1'b0);
        end
        add_entry("ascii16 bank 0 write", c16,
                  write_strobe(16'h6000 | rand_off(16'h07FF), rand8()), 1'b0);
        add_entry("ascii16 switched read", c16, read_strobe(16'h4000 | rand_off(16'h3FFF)), 1'b0);
        add_entry("ascii16 bank 1 write", c16,
                  write_strobe(16'h7000 | rand_off(16'h07FF), rand8()), 1'b0);
        add_entry("ascii16 switched read", c16, read_strobe(16'h8000 | rand_off(16'h3FFF)), 1'b0);
        for (int p = 0; p < 4; p++) begin
            add_entry("konami bank write", ck,
                      write_strobe(page_base(p) | rand_off(16'h1FFF), rand8()), 1'b0);
            add_entry("konami switched read", ck,
                      read_strobe(page_base(p) | rand_off(16'h1FFF)), 1'b0);
        end
        // SRAM, bank 2 then bank 0 which is read only
        add_entry("ascii8 sram bank write", c8s,
                  write_strobe(16'h7000 | rand_off(16'h07FF), rand8() | 8'h20), 1'b0);
        add_entry("ascii8 sram read", c8s, read_strobe(16'h8000 | rand_off(16'h1FFF)), 1'b0);
        add_entry("ascii8 sram write", c8s,
                  write_strobe(16'h8000 | rand_off(16'h1FFF), rand8()), 1'b0);
        add_entry("ascii8 sram bank write", c8s,
                  write_strobe(16'h6000 | rand_off(16'h07FF), rand8() | 8'h20), 1'b0);
        add_entry("ascii8 sram read page 0", c8s, read_strobe(16'h4000 | rand_off(16'h1FFF)), 1'b0);
        add_entry("ascii8 sram write page 0", c8s,
                  write_strobe(16'h4000 | rand_off(16'h1FFF), rand8()), 1'b0);
        add_entry("ascii8 sram disabled read", c8, read_strobe(16'h8000 | rand_off(16'h1FFF)), 1'b0);
        add_entry("ascii16 sram bank write", c16s,
                  write_strobe(16'h7000 | rand_off(16'h07FF), rand8() | 8'h10), 1'b0);
        add_entry("ascii16 sram read", c16s, read_strobe(16'h8000 | rand_off(16'h3FFF)), 1'b0);
        add_entry("ascii16 sram write", c16s,
                  write_strobe(16'h8000 | rand_off(16'h3FFF), rand8()), 1'b0);
        add_entry("ascii16 sram bank write", c16s,
                  write_strobe(16'h6000 | rand_off(16'h07FF), rand8() | 8'h10), 1'b0);
        add_entry("ascii16 sram read page 0", c16s, read_strobe(16'h4000 | rand_off(16'h3FFF)), 1'b0);
        add_entry("ascii16 sram write page 0", c16s,
                  write_strobe(16'h4000 | rand_off(16'h1FFF), rand8()), 1'b0);
        add_entry("ascii16 sram disabled read", c16, read_strobe(16'h8000 | rand_off(16'h3FFF)), 1'b0);
        // Nothing should reach memory here
        add_entry("read below window", c8, read_strobe(rand_off(16'h3FFF)), 1'b0);
        add_entry("read above window", c8, read_strobe(16'hC000 | rand_off(16'h3FFF)), 1'b0);
        add_entry("write above window", c16s, write_strobe(16'hC000 | rand_off(16'h3FFF), rand8()), 1'b0);
        add_entry("no mapper read", cnone, read_strobe(16'h4000 | rand_off(16'h7FFF)), 1'b0);
        add_entry("ascii8 rom write", c8, write_strobe(16'h8000 | rand_off(16'h1FFF), rand8()), 1'b0);
        add_entry("ascii16 rom write", c16, write_strobe(16'h6800 | rand_off(16'h07FF), rand8()), 1'b0);
        // Back to back, bank write then the same page
        add_entry("ascii8 b2b bank write", c8,
                  write_strobe(16'h7800 | rand_off(16'h07FF), rand8()), 1'b1);
        add_entry("ascii8 b2b read", c8, read_strobe(16'hA000 | rand_off(16'h1FFF)), 1'b0);
        add_entry("ascii16 b2b bank write", c16,
                  write_strobe(16'h6000 | rand_off(16'h07FF), rand8()), 1'b1);
        add_entry("ascii16 b2b read", c16, read_strobe(16'h4000 | rand_off(16'h3FFF)), 1'b0);
        add_entry("konami b2b bank write", ck,
                  write_strobe(16'h8000 | rand_off(16'h1FFF), rand8()), 1'b1);
        add_entry("konami b2b read", ck, read_strobe(16'h8000 | rand_off(16'h1FFF)), 1'b0);
    endtask

    task automatic drive_cpu(input cpu_bus_t c, input mapper_cfg_t g);
        @(posedge clk);
        #1;
        cpu = c;
        cfg = g;
    endtask

    // Bus idle while watching memory.req, lat 0 is one cycle after the strobe
    task automatic wait_request(input mapper_cfg_t g, output int cycles);
        cycles = 0;
        drive_cpu('0, g);
        while (!memory.req && cycles < REQ_TIMEOUT) begin
            drive_cpu('0, g);
            cycles++;
        end
    endtask

    task automatic check_memory(input memory_bus_t got, input memory_bus_t exp);
        if (got.addr !== exp.addr) begin
            $display("Mismatch memory.addr: got 0x%h, expected 0x%h", got.addr, exp.addr);
            test_ok = 1'b0;
        end
        if (got.rnw !== exp.rnw) begin
            $display("Mismatch memory.rnw: got 0x%h, expected 0x%h", got.rnw, exp.rnw);
            test_ok = 1'b0;
        end
        if (got.rom_cs !== exp.rom_cs) begin
            $display("Mismatch memory.rom_cs: got 0x%h, expected 0x%h", got.rom_cs, exp.rom_cs);
            test_ok = 1'b0;
        end
        if (got.sram_cs !== exp.sram_cs) begin
            $display("Mismatch memory.sram_cs: got 0x%h, expected 0x%h", got.sram_cs, exp.sram_cs);
            test_ok = 1'b0;
        end
        if (got.wdata !== exp.wdata) begin
            $display("Mismatch memory.wdata: got 0x%h, expected 0x%h", got.wdata, exp.wdata);
            test_ok = 1'b0;
        end
    endtask

    task automatic check_no_request(input memory_bus_t got);
        if (got.req !== 1'b0) begin
            $display("Unexpected memory request to address 0x%h (rom_cs %0b, sram_cs %0b)",
                     got.addr, got.rom_cs, got.sram_cs);
            test_ok = 1'b0;
        end
    endtask

    task automatic report_test(input int idx);
        if (test_ok) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        $display("test %0d %s: %s", idx, names[idx], test_ok ? "ok" : "failed");
    endtask

    initial begin
        seed     = 16;
        pass_cnt = 0;
        fail_cnt = 0;
        clk      = 1'b0;
        rst_n    = 1'b1;
        cpu      = '0;
        cfg      = '0;
        model_reset();
        build_table();
        #1 rst_n = 1'b0;                // Falling edge clears the registers
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        i = 0;
        while (i < tbl.size()) begin
            drive_cpu(tbl[i].cpu, tbl[i].cfg);
            if (tbl[i].chain && i + 1 < tbl.size()) begin
                drive_cpu(tbl[i+1].cpu, tbl[i+1].cfg);  // Strobe right behind
                test_ok = 1'b1;
                check_no_request(memory);               // Bank write result
                report_test(i);
                i++;
            end
            test_ok = 1'b1;
            wait_request(tbl[i].cfg, lat);
            if (tbl[i].exp.req) begin
                if (!memory.req) begin
                    $display("No memory request within %0d cycles", REQ_TIMEOUT + 1);
                    test_ok = 1'b0;
                end else begin
                    if (lat != 0) begin
                        $display("Memory request came %0d cycles late", lat);
                        test_ok = 1'b0;
                    end
                    check_memory(memory, tbl[i].exp);
                end
            end else begin
                check_no_request(memory);
            end
            report_test(i);
            i++;
        end

        $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/cart_ascii16.sv
module cart_ascii16 import msx_cart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu,
    input  mapper_cfg_t cfg,
    output mapper_out_t out
);

    logic [BANK_W-1:0] bank [2];        // 16 KB pages at 0x4000, 0x8000
    logic              sel;
    logic              in_win;
    logic              page;
    logic              reg_wr;
    logic [BANK_W-1:0] cur_bank;
    logic              use_sram;

    assign sel    = (cfg.typ == MAP_ASCII16);
    assign in_win = cpu.addr[15] ^ cpu.addr[14];
    assign page   = cpu.addr[15];

    // Bank 0 at 0x6000-0x67FF, bank 1 at 0x7000-0x77FF
    assign reg_wr = sel & cpu.req & ~cpu.rnw
                  & (cpu.addr[15:13] == 3'b011) & ~cpu.addr[11];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank[0] <= '0;
            bank[1] <= '0;
        end else if (reg_wr) begin
            bank[cpu.addr[12]] <= cpu.wdata;    // addr[12] picks the register
        end
    end

    assign cur_bank = bank[page];
    assign use_sram = cfg.sram_en & cur_bank[ASCII16_SRAM_BIT];

    always_comb begin
        out = MAPPER_OUT_NEUTRAL;
        if (sel && cpu.req && in_win) begin
            if (use_sram) begin
                // 2 KB SRAM, mirrored across the page
                if (cpu.rnw || page) begin
                    out.addr    = MEM_ADDR_W'(cpu.addr[ASCII16_SRAM_ADDR_W-1:0]);
                    out.rnw     = cpu.rnw;
                    out.sram_cs = 1'b1;
                end
            end else if (cpu.rnw) begin
                out.addr   = {cur_bank & cfg.rom_mask, cpu.addr[13:0]};  // Exactly 22 bits
                out.rnw    = 1'b1;
                out.rom_cs = 1'b1;
            end
        end
    end

endmodule

// File: verilog/cart_ascii8.sv
module cart_ascii8 import msx_cart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu,
    input  mapper_cfg_t cfg,
    output mapper_out_t out
);

    logic [BANK_W-1:0] bank [4];        // One per 8 KB page
    logic              sel;
    logic              in_win;
    logic [1:0]        page;
    logic              reg_wr;
    logic [BANK_W-1:0] cur_bank;
    logic              use_sram;
    logic              sram_wr_ok;

    assign sel    = (cfg.typ == MAP_ASCII8);
    assign in_win = cpu.addr[15] ^ cpu.addr[14];    // 0x4000-0xBFFF

    // 010->0, 011->1, 100->2, 101->3
    assign page = {cpu.addr[15], cpu.addr[13]};

    // Register area 0x6000-0x7FFF, 2 KB per register
    assign reg_wr = sel & cpu.req & ~cpu.rnw & (cpu.addr[15:13] == 3'b011);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= '0;
            end
        end else if (reg_wr) begin
            bank[cpu.addr[12:11]] <= cpu.wdata;  // 0x6000/0x6800/0x7000/0x7800
        end
    end

    assign cur_bank   = bank[page];
    assign use_sram   = cfg.sram_en & cur_bank[ASCII8_SRAM_BIT];
    assign sram_wr_ok = cpu.addr[15];           // Pages 2 and 3 only

    // Register writes land in page 1, never writable, so they stay local
    always_comb begin
        out = MAPPER_OUT_NEUTRAL;
        if (sel && cpu.req && in_win) begin
            if (use_sram) begin
                if (cpu.rnw || sram_wr_ok) begin
                    out.addr    = MEM_ADDR_W'(cpu.addr[SRAM_ADDR_W-1:0]);
                    out.rnw     = cpu.rnw;
                    out.sram_cs = 1'b1;
                end
            end else if (cpu.rnw) begin
                // Masked bank followed by 8 KB offset
                out.addr   = MEM_ADDR_W'({cur_bank & cfg.rom_mask, cpu.addr[12:0]});
                out.rnw    = 1'b1;
                out.rom_cs = 1'b1;
            end
            // ROM writes dropped
        end
    end

endmodule

// File: verilog/cart_slot.sv
module cart_slot import msx_cart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu,            // Slot strobe from the CPU
    input  mapper_cfg_t cfg,            // Static, changed only when idle
    output memory_bus_t memory          // To external ROM/SRAM
);

    // All decode and registering lives in the combiner
    mappers mappers_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .cpu    (cpu),
        .cfg    (cfg),
        .memory (memory)
    );

endmodule

// File: verilog/mapper_konami.sv
module mapper_konami import msx_cart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu,
    input  mapper_cfg_t cfg,
    output mapper_out_t out
);

    logic [BANK_W-1:0] bank1;           // 0x6000-0x7FFF
    logic [BANK_W-1:0] bank2;           // 0x8000-0x9FFF
    logic [BANK_W-1:0] bank3;           // 0xA000-0xBFFF
    logic              sel;
    logic              in_win;
    logic [1:0]        page;
    logic              wr;
    logic [BANK_W-1:0] cur_bank;

    assign sel    = (cfg.typ == MAP_KONAMI);
    assign in_win = cpu.addr[15] ^ cpu.addr[14];
    assign page   = {cpu.addr[15], cpu.addr[13]};
    assign wr     = sel & cpu.req & ~cpu.rnw & in_win;

    // Any write inside a switchable page reloads its bank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank1 <= KONAMI_RST_BANK1;
            bank2 <= KONAMI_RST_BANK2;
            bank3 <= KONAMI_RST_BANK3;
        end else if (wr) begin
            case (page)
                2'd1:    bank1 <= cpu.wdata;
                2'd2:    bank2 <= cpu.wdata;
                2'd3:    bank3 <= cpu.wdata;
                default: ;                      // Page 0 hardwired
            endcase
        end
    end

    always_comb begin
        case (page)
            2'd1:    cur_bank = bank1;
            2'd2:    cur_bank = bank2;
            2'd3:    cur_bank = bank3;
            default: cur_bank = '0;
        endcase
    end

    // Reads only, no SRAM on this board
    always_comb begin
        out = MAPPER_OUT_NEUTRAL;
        if (sel && cpu.req && in_win && cpu.rnw) begin
            out.addr   = MEM_ADDR_W'({cur_bank & cfg.rom_mask, cpu.addr[12:0]});
            out.rnw    = 1'b1;
            out.rom_cs = 1'b1;
        end
    end

endmodule

// File: verilog/mappers.sv
module mappers import msx_cart_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cpu_bus_t    cpu,
    input  mapper_cfg_t cfg,
    output memory_bus_t memory
);

    mapper_out_t ascii8_out;            // Neutral unless typ selects it
    mapper_out_t ascii16_out;
    mapper_out_t konami_out;
    mapper_out_t merged;

    logic                  req_q;
    logic                  rom_cs_q;
    logic                  sram_cs_q;
    logic [MEM_ADDR_W-1:0] addr_q;
    logic                  rnw_q;
    logic [DATA_W-1:0]     wdata_q;

    cart_ascii8 ascii8 (
        .clk   (clk),
        .rst_n (rst_n),
        .cpu   (cpu),
        .cfg   (cfg),
        .out   (ascii8_out)
    );

    cart_ascii16 ascii16 (
        .clk   (clk),
        .rst_n (rst_n),
        .cpu   (cpu),
        .cfg   (cfg),
        .out   (ascii16_out)
    );

    mapper_konami konami (
        .clk   (clk),
        .rst_n (rst_n),
        .cpu   (cpu),
        .cfg   (cfg),
        .out   (konami_out)
    );

    // Idle mappers drive all-ones addr/rnw and zero selects
    assign merged.addr    = ascii8_out.addr & ascii16_out.addr & konami_out.addr;
    assign merged.rnw     = ascii8_out.rnw & ascii16_out.rnw & konami_out.rnw;
    assign merged.rom_cs  = ascii8_out.rom_cs | ascii16_out.rom_cs | konami_out.rom_cs;
    assign merged.sram_cs = ascii8_out.sram_cs | ascii16_out.sram_cs | konami_out.sram_cs;

    // Strobe and selects, one cycle behind cpu.req
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q     <= 1'b0;
            rom_cs_q  <= 1'b0;
            sram_cs_q <= 1'b0;
        end else begin
            req_q     <= merged.rom_cs | merged.sram_cs;
            rom_cs_q  <= merged.rom_cs;
            sram_cs_q <= merged.sram_cs;
        end
    end

    // Payload, only meaningful with req_q
    always_ff @(posedge clk) begin
        addr_q  <= merged.addr;
        rnw_q   <= merged.rnw;
        wdata_q <= cpu.wdata;
    end

    assign memory = '{
        req:     req_q,
        addr:    addr_q,
        rnw:     rnw_q,
        rom_cs:  rom_cs_q,
        sram_cs: sram_cs_q,
        wdata:   wdata_q
    };

endmodule

// File: verilog/msx_cart_pkg.sv
package msx_cart_pkg;

    // Bus widths
    localparam int CPU_ADDR_W  = 16;    // Z80 address space
    localparam int MEM_ADDR_W  = 22;    // 256 banks of 16 KB
    localparam int SRAM_ADDR_W = 13;    // 8 KB battery SRAM
    localparam int DATA_W      = 8;
    localparam int BANK_W      = 8;     // Bank register width, all mappers

    // ASCII16 only decodes 2 KB of SRAM
    localparam int ASCII16_SRAM_ADDR_W = 11;

    // Bank value bit that swaps ROM for SRAM
    localparam int ASCII8_SRAM_BIT  = 5;
    localparam int ASCII16_SRAM_BIT = 4;

    // Reset banks of Konami pages 1..3
    localparam logic [BANK_W-1:0] KONAMI_RST_BANK1 = 8'd1;
    localparam logic [BANK_W-1:0] KONAMI_RST_BANK2 = 8'd2;
    localparam logic [BANK_W-1:0] KONAMI_RST_BANK3 = 8'd3;

    typedef enum logic [1:0] {
        MAP_NONE    = 2'd0,
        MAP_ASCII8  = 2'd1,
        MAP_ASCII16 = 2'd2,
        MAP_KONAMI  = 2'd3
    } mapper_typ_e;

    // CPU side strobe, valid for one cycle
    typedef struct packed {
        logic                  req;
        logic                  rnw;     // 1 = read
        logic [CPU_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } cpu_bus_t;

    // Static slot configuration
    typedef struct packed {
        mapper_typ_e       typ;
        logic [BANK_W-1:0] rom_mask;    // ANDed onto every bank number
        logic              sram_en;     // Gates the SRAM select bit
    } mapper_cfg_t;

    // Per-mapper result, merged by AND/OR in the combiner
    typedef struct packed {
        logic [MEM_ADDR_W-1:0] addr;
        logic                  rnw;
        logic                  rom_cs;
        logic                  sram_cs;
    } mapper_out_t;

    // Idle value, transparent to the AND/OR merge
    localparam mapper_out_t MAPPER_OUT_NEUTRAL = '{
        addr:    '1,
        rnw:     1'b1,
        rom_cs:  1'b0,
        sram_cs: 1'b0
    };

    // Registered request towards ROM/SRAM
    typedef struct packed {
        logic                  req;
        logic [MEM_ADDR_W-1:0] addr;
        logic                  rnw;
        logic                  rom_cs;
        logic                  sram_cs;
        logic [DATA_W-1:0]     wdata;
    } memory_bus_t;

endpackage
